// File: logic/nn_cfg.svh
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

//**************************************************************************
// word format and layer sizes
//**************************************************************************

`define DATA_WIDTH 16

`define N_INPUTS   4
`define N_HIDDEN   3
`define N_OUTPUTS  2

`define CLASS_BITS 1     // enough for N_OUTPUTS classes

//**************************************************************************
// fixed weights and biases
//**************************************************************************

// word n sits at bits [n*16 +: 16], so each concatenation lists the
// highest word first; row j of a weight list belongs to neuron j

// hidden neuron 0 : 3, -2, 5, 1    bias 8
// hidden neuron 1 : -4, 7, 2, -3   bias -5
// hidden neuron 2 : 6, 1, -1, 4    bias 0
`define HIDDEN_WEIGHTS { \
	16'sd4,  -16'sd1, 16'sd1,  16'sd6, \
	-16'sd3, 16'sd2,  16'sd7,  -16'sd4, \
	16'sd1,  16'sd5,  -16'sd2, 16'sd3 \
}

`define HIDDEN_BIASES {16'sd0, -16'sd5, 16'sd8}

// output neuron 0 : 2, -1, 3   bias 2
// output neuron 1 : -1, 3, 1   bias 26
`define OUTPUT_WEIGHTS { \
	16'sd1, 16'sd3,  -16'sd1, \
	16'sd3, -16'sd1, 16'sd2 \
}

// all-zero features give 18 on both outputs
`define OUTPUT_BIASES {16'sd26, 16'sd2}

`endif

// File: logic/nnPkg.sv
`default_nettype none

`include "nn_cfg.svh"

package nnPkg;

	//**********************************************************************
	// basic word
	//**********************************************************************

	// two's complement, sums wrap at this width
	typedef logic [`DATA_WIDTH-1:0] dataWord;

	//**********************************************************************
	// vectors between the stages
	//**********************************************************************

	// input features, word 0 is feature 0
	typedef struct packed
	{
		dataWord [`N_INPUTS-1:0] words;
	} featureVec;

	typedef struct packed
	{
		dataWord [`N_HIDDEN-1:0] words;   // hidden layer activations
	} hiddenVec;

	typedef struct packed
	{
		dataWord [`N_OUTPUTS-1:0] words;  // one score per class
	} scoreVec;

	// winning class and its score
	typedef struct packed
	{
		logic [`CLASS_BITS-1:0] classIdx;
		dataWord                score;
	} classResult;

endpackage

`default_nettype wire

// File: logic/neuron.sv
`default_nettype none

// registered multiply-accumulate node with ReLU output
// three register stages, inputs -> sum -> activation
module neuron
	import nnPkg::*;
#(
	parameter int                    NINPUTS = 4,
	parameter dataWord [NINPUTS-1:0] WEIGHTS = '0,  // word i scales input i
	parameter dataWord               BIAS    = '0
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  dataWord [NINPUTS-1:0] inputs,
	output dataWord               activation
);

	localparam int SIGN_BIT = $bits(dataWord) - 1;

	dataWord [NINPUTS-1:0] inputsReg;   // stage 1
	dataWord [NINPUTS-1:0] products;
	dataWord               sumNext;
	dataWord               sumReg;      // stage 2
	dataWord               reluNext;

	//**********************************************************************
	// products and sum
	//**********************************************************************

	// keep only the low word of each product
	always_comb
	begin
		for (int i = 0; i < NINPUTS; i++)
		begin
			products[i] = dataWord'(inputsReg[i] * WEIGHTS[i]);
		end
	end

	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < NINPUTS; i++)
		begin
			sumNext = sumNext + products[i];   // wraps mod 2^16
		end
	end

	//**********************************************************************
	// ReLU
	//**********************************************************************

	// negative sums clamp to zero
	always_comb
	begin
		if (sumReg[SIGN_BIT])
		begin
			reluNext = '0;
		end
		else
		begin
			reluNext = sumReg;
		end
	end

	//**********************************************************************
	// pipeline registers
	//**********************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg  <= '0;
			sumReg     <= '0;
			activation <= '0;
		end
		else
		begin
			inputsReg  <= inputs;
			sumReg     <= sumNext;
			activation <= reluNext;   // stage 3
		end
	end

endmodule

`default_nettype wire

// File: logic/denseLayer.sv
`default_nettype none

// fully connected layer
// every neuron sees the whole input vector, all run side by side
module denseLayer
	import nnPkg::*;
#(
	parameter int                                NINPUTS  = 4,
	parameter int                                NNEURONS = 3,
	// row n, words n*NINPUTS .. n*NINPUTS+NINPUTS-1, feeds neuron n
	parameter dataWord [NNEURONS*NINPUTS-1:0] WEIGHTS  = '0,
	parameter dataWord [NNEURONS-1:0]          BIASES   = '0
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  dataWord [NINPUTS-1:0]  inputs,
	output dataWord [NNEURONS-1:0] activations
);

	//**********************************************************************
	// one neuron per output word
	//**********************************************************************

	genvar n;

	generate
		for (n = 0; n < NNEURONS; n++)
		begin : g_neuron
			// slice out this neuron's weight row
			localparam dataWord [NINPUTS-1:0] ROW_WEIGHTS =
				WEIGHTS[n*NINPUTS +: NINPUTS];

			neuron #(
				.NINPUTS (NINPUTS),
				.WEIGHTS (ROW_WEIGHTS),
				.BIAS    (BIASES[n])
			) u_neuron (
				.clk        (clk),
				.reset      (reset),
				.inputs     (inputs),
				.activation (activations[n])
			);
		end
	endgenerate

endmodule

`default_nettype wire

// File: logic/classArgmax.sv
`default_nettype none

`include "nn_cfg.svh"

// picks the largest output score, one register stage
module classArgmax
	import nnPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  scoreVec    scores,
	output classResult result
);

	logic [`CLASS_BITS-1:0] bestIdx;
	dataWord                bestScore;
	classResult             bestNext;

	//**********************************************************************
	// comparison
	//**********************************************************************

	// scores come out of ReLU so unsigned compare is enough
	// strict greater keeps the lower index on a tie
	always_comb
	begin
		bestIdx   = '0;
		bestScore = scores.words[0];
		for (int i = 1; i < `N_OUTPUTS; i++)
		begin
			if (scores.words[i] > bestScore)
			begin
				bestIdx   = i[`CLASS_BITS-1:0];
				bestScore = scores.words[i];
			end
		end
	end

	always_comb
	begin
		bestNext.classIdx = bestIdx;
		bestNext.score    = bestScore;
	end

	//**********************************************************************
	// output register
	//**********************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;   // class 0, score 0
		end
		else
		begin
			result <= bestNext;
		end
	end

endmodule

`default_nettype wire

// File: logic/mlpClassifier.sv
`default_nettype none

`include "nn_cfg.svh"

// two-layer fixed-weight classifier
// scores trail features by 6 cycles, result by 7
module mlpClassifier
	import nnPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  featureVec  features,
	output scoreVec    scores,
	output classResult result
);

	hiddenVec hidden;   // hidden activations, 3 cycles behind features

	//**********************************************************************
	// hidden layer
	//**********************************************************************

	denseLayer #(
		.NINPUTS  (`N_INPUTS),
		.NNEURONS (`N_HIDDEN),
		.WEIGHTS  (`HIDDEN_WEIGHTS),
		.BIASES   (`HIDDEN_BIASES)
	) hiddenLayer (
		.clk         (clk),
		.reset       (reset),
		.inputs      (features.words),
		.activations (hidden.words)
	);

	//**********************************************************************
	// output layer and class pick
	//**********************************************************************

	denseLayer #(
		.NINPUTS  (`N_HIDDEN),
		.NNEURONS (`N_OUTPUTS),
		.WEIGHTS  (`OUTPUT_WEIGHTS),
		.BIASES   (`OUTPUT_BIASES)
	) outputLayer (
		.clk         (clk),
		.reset       (reset),
		.inputs      (hidden.words),
		.activations (scores.words)
	);

	classArgmax u_classArgmax (
		.clk    (clk),
		.reset  (reset),
		.scores (scores),
		.result (result)    // one cycle after scores
	);

endmodule

`default_nettype wire

// File: test/mlpModel.svh
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// expected network outputs, worked out word by word from the node rules

localparam int FAN_IN = `N_INPUTS;   // widest layer input

localparam dataWord [`N_HIDDEN*`N_INPUTS-1:0]  HIDDEN_W = `HIDDEN_WEIGHTS;
localparam dataWord [`N_HIDDEN-1:0]            HIDDEN_B = `HIDDEN_BIASES;
localparam dataWord [`N_OUTPUTS*`N_HIDDEN-1:0] OUTPUT_W = `OUTPUT_WEIGHTS;
localparam dataWord [`N_OUTPUTS-1:0]           OUTPUT_B = `OUTPUT_BIASES;

// low word of each product, sum wraps, bit 15 set clamps to zero
function automatic dataWord nodeModel(
	input dataWord [FAN_IN-1:0] x,
	input dataWord [FAN_IN-1:0] w,
	input dataWord              bias
);
	logic [2*`DATA_WIDTH-1:0] full;
	dataWord                  acc;
	acc = bias;
	for (int i = 0; i < FAN_IN; i++)
	begin
		full = x[i] * w[i];
		acc  = acc + full[`DATA_WIDTH-1:0];
	end
	if (acc[`DATA_WIDTH-1])
	begin
		acc = '0;
	end
	return acc;
endfunction

function automatic hiddenVec hiddenModel(input featureVec f);
	hiddenVec h;
	for (int j = 0; j < `N_HIDDEN; j++)
	begin
		h.words[j] = nodeModel(f.words, HIDDEN_W[j*`N_INPUTS +: `N_INPUTS], HIDDEN_B[j]);
	end
	return h;
endfunction

function automatic scoreVec scoreModel(input featureVec f);
	hiddenVec             h;
	dataWord [FAN_IN-1:0] x;
	dataWord [FAN_IN-1:0] w;
	scoreVec              s;
	h = hiddenModel(f);
	x = '0;   // spare words stay zero
	x[`N_HIDDEN-1:0] = h.words;
	for (int k = 0; k < `N_OUTPUTS; k++)
	begin
		w = '0;
		w[`N_HIDDEN-1:0] = OUTPUT_W[k*`N_HIDDEN +: `N_HIDDEN];
		s.words[k] = nodeModel(x, w, OUTPUT_B[k]);
	end
	return s;
endfunction

// ties go to the lower index
function automatic classResult classModel(input scoreVec s);
	classResult r;
	r.classIdx = '0;
	r.score    = s.words[0];
	for (int i = 1; i < `N_OUTPUTS; i++)
	begin
		if (s.words[i] > r.score)
		begin
			r.classIdx = `CLASS_BITS'(i);
			r.score    = s.words[i];
		end
	end
	return r;
endfunction

`endif

// File: test/mlpTb.sv
`default_nettype none

`include "nn_cfg.svh"

module mlpTb
	import nnPkg::*;
();

	`include "mlpModel.svh"

	localparam int TEST_CYCLES = 150;   // 6 + 32 + 24 + 8 + 47 + 33
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 50;

	logic       clk;
	logic       reset;
	featureVec  features;
	scoreVec    scores;
	classResult result;

	featureVec featHist[$];      // input applied at each falling edge
	int        cleanSteps = 0;   // falling edges since reset was last driven high
	int        errorCount = 0;
	int        checkCount = 0;
	int        cycleCount = 0;
	int        seed = 36;

	mlpClassifier u_mlpClassifier (
		.clk      (clk),
		.reset    (reset),
		.features (features),
		.scores   (scores),
		.result   (result)
	);

	initial
	begin
		clk = 1'b1;   // first falling edge comes before the first rising one
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	initial
	begin
		wait (cycleCount >= CYCLE_LIMIT);
		$display("timeout, tests still running after %0d cycles", cycleCount);
		$display("SOME TESTS FAILED");
		$finish;
	end

	//**************************************************************************
	// checking and driving
	//**************************************************************************

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// outputs seen here come from the edge after the previous drive
	task automatic stepCycle(input featureVec vec, input logic rst);
		scoreVec    expScores;
		classResult expResult;
		int         n;
		@(negedge clk);
		n = featHist.size();
		expScores = '0;   // reset on the last edge clears every stage
		expResult = '0;
		if (cleanSteps >= 6)
		begin
			expScores = scoreModel(featHist[n-6]);
		end
		if (cleanSteps >= 7)
		begin
			expResult = classModel(scoreModel(featHist[n-7]));
		end
		if (n > 0 && (cleanSteps == 0 || cleanSteps >= 6))
		begin
			compareValue("scores", expScores, scores);
		end
		if (n > 0 && (cleanSteps == 0 || cleanSteps >= 7))
		begin
			compareValue("result", expResult, result);
		end
		features = vec;
		reset    = rst;
		featHist.push_back(vec);
		cleanSteps = rst ? 0 : cleanSteps + 1;
	endtask

	// held until it reaches result, then the settled outputs
	task automatic holdVector(input featureVec vec);
		repeat (8)
			stepCycle(vec, 1'b0);
		compareValue("scores", scoreModel(vec), scores);
		compareValue("result", classModel(scoreModel(vec)), result);
	endtask

	//**************************************************************************
	// tests
	//**************************************************************************

	task automatic resetAtStart();
		repeat (4)
			stepCycle('0, 1'b1);
		stepCycle('0, 1'b0);
		stepCycle('0, 1'b0);
		compareValue("scores", '0, scores);   // first edge out of reset
		compareValue("result", '0, result);
	endtask

	task automatic singleVectors();
		holdVector('0);                               // biases only
		holdVector({16'd4, 16'd3, 16'd2, 16'd1});
		holdVector({16'd0, 16'd0, 16'd5, 16'd0});    // hidden 0 sums to -2
		holdVector({16'd0, 16'd0, 16'd0, 16'd10});   // hidden 1 sums to -45
	endtask

	task automatic wraparound();
		holdVector({16'd0, 16'd0, 16'd0, 16'h3000});   // 3 * 0x3000 + 8 sets bit 15
		holdVector({16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff});
		holdVector({16'hfff0, 16'h1234, 16'hc000, 16'h8001});
	endtask

	task automatic argmaxTie();
		scoreVec tieScores;
		tieScores = scoreModel('0);
		if (tieScores.words[0] !== tieScores.words[1])
		begin
			errorCount++;
			$display("zero vector does not give equal scores in the model");
		end
		holdVector('0);
		compareValue("result.classIdx", 0, result.classIdx);
	endtask

	task automatic streaming();
		repeat (40)
			stepCycle({$random(seed), $random(seed)}, 1'b0);
		repeat (7)
			stepCycle('0, 1'b0);   // drain the pipeline
	endtask

	task automatic resetMidStream();
		repeat (10)
			stepCycle({$random(seed), $random(seed)}, 1'b0);
		stepCycle({$random(seed), $random(seed)}, 1'b1);
		repeat (15)
			stepCycle({$random(seed), $random(seed)}, 1'b0);
		repeat (7)
			stepCycle('0, 1'b0);
	endtask

	initial
	begin
		reset    = 1'b1;
		features = '0;
		resetAtStart();
		singleVectors();
		wraparound();
		argmaxTie();
		streaming();
		resetMidStream();
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
+incdir+test
logic/nnPkg.sv
logic/neuron.sv
logic/denseLayer.sv
logic/classArgmax.sv
logic/mlpClassifier.sv
test/mlpTb.sv
